// File: ebusPkg.sv
package ebusPkg;

  // one EBUS data word, numbered 35..0 here rather than the KL10 0..35
  localparam int ebusWordWidth = 36;

  // Wishbone byte-free word address: device code in 4..2, function in 1..0
  localparam int wbAdrWidth = 5;

  localparam int aprFlagCount = 8;

  // levels 1..7 live in bits 0..6, level 0 means no level
  localparam int piLevelCount = 7;
  localparam int piLevelWidth = 3;

  typedef logic [ebusWordWidth-1:0] ebusWordT;

  typedef logic [piLevelWidth-1:0] piLevelT;

  // codes 3..7 decode to no device and read back as zero
  typedef enum logic [2:0] {
    devApr = 3'd0,
    devPi  = 3'd1,
    devMtr = 3'd2
  } ebusDevT;

  // bit 1 set means the host writes, clear means the device drives
  typedef enum logic [1:0] {
    funcDatai = 2'd0,
    funcConi  = 2'd1,
    funcDatao = 2'd2,
    funcCono  = 2'd3
  } ebusFuncT;

  // true for the two functions that put a device on the bus
  function automatic logic isReadFunc(ebusFuncT func);
    return (func == funcDatai) || (func == funcConi);
  endfunction

endpackage

// File: ebusHostBridge.sv
module ebusHostBridge
  import ebusPkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic [wbAdrWidth-1:0] adr,
  input  ebusWordT              datIn,
  output ebusWordT              datOut,
  output logic                  ack,
  output logic                  ebusReq,
  output ebusDevT               ebusCs,
  output ebusFuncT              ebusFunc,
  output ebusWordT              ebusDataOut,
  input  ebusWordT              ebusData
);

  // one Wishbone cycle becomes exactly one EBUS transfer
  typedef enum logic [1:0] {
    stIdle    = 2'd0,
    stRequest = 2'd1,
    stCapture = 2'd2
  } bridgeStateT;

  bridgeStateT state;
  logic        start;

  // a new cycle is only taken from idle, and never while ack is still up,
  // since the master keeps stb high through the ack cycle
  assign start = (state == stIdle) && cyc && stb && !ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stIdle;
      ack   <= 1'b0;
    end else begin
      ack <= 1'b0;
      case (state)
        stIdle: begin
          if (start) begin
            state <= stRequest;
          end
        end
        stRequest: begin
          // devices apply writes or load their drivers at this edge
          state <= stCapture;
        end
        stCapture: begin
          state <= stIdle;
          ack   <= 1'b1;
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  // request fields are latched once and held for the whole transfer
  always_ff @(posedge clk) begin
    if (start) begin
      ebusCs      <= ebusDevT'(adr[wbAdrWidth-1:2]);
      ebusFunc    <= ebusFuncT'(adr[1:0]);
      ebusDataOut <= datIn;
    end
    if (state == stCapture) begin
      datOut <= ebusData;
    end
  end

  // the strobe lasts exactly the one request cycle
  assign ebusReq = (state == stRequest);

  // the master must still be holding its cycle when the slave answers
  ackInsideCycle: assert property (
    @(posedge clk) disable iff (reset)
    ack |-> (cyc && stb)
  ) else $error("ack raised outside a Wishbone cycle");

endmodule

// File: aprRegs.sv
module aprRegs
  import ebusPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ebusReq,
  input  ebusDevT                 ebusCs,
  input  ebusFuncT                ebusFunc,
  input  ebusWordT                ebusDataOut,
  input  logic [aprFlagCount-1:0] errorEvents,
  output logic                    aprDriving,
  output ebusWordT                aprData,
  output logic                    aprIntReq,
  output piLevelT                 aprPiLevel
);

  logic [aprFlagCount-1:0] flags;
  logic [aprFlagCount-1:0] enables;
  piLevelT                 level;
  ebusWordT                breakReg;
  logic                    selected;
  logic [aprFlagCount-1:0] flagsNext;

  assign selected = ebusReq && (ebusCs == devApr);

  // CONO clears first, then sets, and error events land on top of that
  always_comb begin
    flagsNext = flags;
    if (selected && (ebusFunc == funcCono)) begin
      flagsNext = flagsNext & ~ebusDataOut[15:8];
      flagsNext = flagsNext | ebusDataOut[7:0];
    end
    flagsNext = flagsNext | errorEvents;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags      <= '0;
      enables    <= '0;
      level      <= '0;
      breakReg   <= '0;
      aprDriving <= 1'b0;
    end else begin
      flags      <= flagsNext;
      aprDriving <= selected && isReadFunc(ebusFunc);
      if (selected && (ebusFunc == funcCono)) begin
        enables <= ebusDataOut[23:16];
        level   <= ebusDataOut[26:24];
      end
      if (selected && (ebusFunc == funcDatao)) begin
        breakReg <= ebusDataOut;
      end
    end
  end

  // the read word only matters while aprDriving is high
  always_ff @(posedge clk) begin
    if (selected && (ebusFunc == funcConi)) begin
      aprData <= {17'd0, level, enables, flags};
    end else begin
      aprData <= breakReg;
    end
  end

  assign aprIntReq  = |(flags & enables);
  assign aprPiLevel = level;

endmodule

// File: piCtrl.sv
module piCtrl
  import ebusPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ebusReq,
  input  ebusDevT                 ebusCs,
  input  ebusFuncT                ebusFunc,
  input  ebusWordT                ebusDataOut,
  input  logic                    aprIntReq,
  input  piLevelT                 aprPiLevel,
  input  logic [piLevelCount-1:0] piReqIn,
  output logic                    piDriving,
  output ebusWordT                piData,
  output piLevelT                 piLevel,
  output logic                    piRequest
);

  logic [piLevelCount-1:0] levelsOn;
  logic                    sysOn;
  logic [piLevelCount-1:0] aprMask;
  logic [piLevelCount-1:0] pending;
  logic [piLevelCount-1:0] active;
  logic                    selected;

  // lowest-numbered active level wins, zero when none is active
  function automatic piLevelT lowestLevel(logic [piLevelCount-1:0] bits);
    piLevelT found;
    found = '0;
    for (int i = piLevelCount - 1; i >= 0; i--) begin
      if (bits[i]) begin
        found = piLevelT'(i + 1);
      end
    end
    return found;
  endfunction

  assign selected = ebusReq && (ebusCs == devPi);

  // the APR asks at its assigned level, level 0 keeps it quiet
  always_comb begin
    aprMask = '0;
    if (aprIntReq && (aprPiLevel != '0)) begin
      aprMask[aprPiLevel - 1'b1] = 1'b1;
    end
  end

  assign pending = piReqIn | aprMask;
  assign active  = pending & levelsOn & {piLevelCount{sysOn}};

  always_ff @(posedge clk) begin
    if (reset) begin
      levelsOn  <= '0;
      sysOn     <= 1'b0;
      piDriving <= 1'b0;
      piLevel   <= '0;
      piRequest <= 1'b0;
    end else begin
      piDriving <= selected && isReadFunc(ebusFunc);
      piLevel   <= lowestLevel(active);
      piRequest <= |active;
      if (selected && (ebusFunc == funcCono)) begin
        // bit 16 wipes the system before the other fields apply
        levelsOn <= ((ebusDataOut[16] ? '0 : levelsOn) & ~ebusDataOut[13:7])
                    | ebusDataOut[6:0];
        if (ebusDataOut[14]) begin
          sysOn <= 1'b1;
        end else if (ebusDataOut[15] || ebusDataOut[16]) begin
          sysOn <= 1'b0;
        end
      end
    end
  end

  // DATAI has nothing behind it here and reads as zero
  always_ff @(posedge clk) begin
    if (selected && (ebusFunc == funcConi)) begin
      piData <= {21'd0, pending, sysOn, levelsOn};
    end else begin
      piData <= '0;
    end
  end

  levelWithRequest: assert property (
    @(posedge clk) disable iff (reset)
    piRequest |-> (piLevel != '0)
  ) else $error("interrupt request without a level");

endmodule

// File: mtrTimeBase.sv
module mtrTimeBase
  import ebusPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     ebusReq,
  input  ebusDevT  ebusCs,
  input  ebusFuncT ebusFunc,
  input  ebusWordT ebusDataOut,
  output logic     mtrDriving,
  output ebusWordT mtrData
);

  ebusWordT timeBase;
  logic     enable;
  logic     selected;
  logic     conoHit;

  assign selected = ebusReq && (ebusCs == devMtr);
  assign conoHit  = selected && (ebusFunc == funcCono);

  always_ff @(posedge clk) begin
    if (reset) begin
      timeBase   <= '0;
      enable     <= 1'b0;
      mtrDriving <= 1'b0;
    end else begin
      mtrDriving <= selected && isReadFunc(ebusFunc);
      if (conoHit) begin
        enable <= ebusDataOut[0];
      end
      // a clear wins over the count on the same edge
      if (conoHit && ebusDataOut[1]) begin
        timeBase <= '0;
      end else if (enable) begin
        timeBase <= timeBase + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (selected && (ebusFunc == funcConi)) begin
      mtrData <= {35'd0, enable};
    end else begin
      mtrData <= timeBase;
    end
  end

endmodule

// File: ebusDriverMux.sv
module ebusDriverMux
  import ebusPkg::*;
(
  input  logic     clk,
  input  logic     aprDriving,
  input  ebusWordT aprData,
  input  logic     piDriving,
  input  ebusWordT piData,
  input  logic     mtrDriving,
  input  ebusWordT mtrData,
  output ebusWordT ebusData
);

  // fixed priority APR, PI, MTR as on the real backplane
  always_comb begin
    if (aprDriving) begin
      ebusData = aprData;
    end else if (piDriving) begin
      ebusData = piData;
    end else if (mtrDriving) begin
      ebusData = mtrData;
    end else begin
      ebusData = '0;
    end
  end

  // the bridge addresses one device at a time, so the priority never
  // has to break a tie
  singleDriver: assert property (
    @(posedge clk)
    $onehot0({aprDriving, piDriving, mtrDriving})
  ) else $error("more than one device drives the EBUS");

endmodule

// File: ebusTop.sv
module ebusTop
  import ebusPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cyc,
  input  logic                    stb,
  input  logic                    we,
  input  logic [wbAdrWidth-1:0]   adr,
  input  ebusWordT                datIn,
  output ebusWordT                datOut,
  output logic                    ack,
  input  logic [aprFlagCount-1:0] errorEvents,
  input  logic [piLevelCount-1:0] piReqIn,
  output piLevelT                 piLevel,
  output logic                    piRequest
);

  logic     ebusReq;
  ebusDevT  ebusCs;
  ebusFuncT ebusFunc;
  ebusWordT ebusDataOut;
  ebusWordT ebusData;
  logic     aprDriving;
  ebusWordT aprData;
  logic     piDriving;
  ebusWordT piData;
  logic     mtrDriving;
  ebusWordT mtrData;
  logic     aprIntReq;
  piLevelT  aprPiLevel;

  // we stays on the port for bus compliance, the direction comes from adr
  ebusHostBridge bridge (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .adr(adr),
    .datIn(datIn), .datOut(datOut), .ack(ack),
    .ebusReq(ebusReq), .ebusCs(ebusCs), .ebusFunc(ebusFunc),
    .ebusDataOut(ebusDataOut), .ebusData(ebusData)
  );

  aprRegs apr (
    .clk(clk), .reset(reset), .ebusReq(ebusReq), .ebusCs(ebusCs),
    .ebusFunc(ebusFunc), .ebusDataOut(ebusDataOut), .errorEvents(errorEvents),
    .aprDriving(aprDriving), .aprData(aprData),
    .aprIntReq(aprIntReq), .aprPiLevel(aprPiLevel)
  );

  piCtrl pi (
    .clk(clk), .reset(reset), .ebusReq(ebusReq), .ebusCs(ebusCs),
    .ebusFunc(ebusFunc), .ebusDataOut(ebusDataOut),
    .aprIntReq(aprIntReq), .aprPiLevel(aprPiLevel), .piReqIn(piReqIn),
    .piDriving(piDriving), .piData(piData),
    .piLevel(piLevel), .piRequest(piRequest)
  );

  mtrTimeBase mtr (
    .clk(clk), .reset(reset), .ebusReq(ebusReq), .ebusCs(ebusCs),
    .ebusFunc(ebusFunc), .ebusDataOut(ebusDataOut),
    .mtrDriving(mtrDriving), .mtrData(mtrData)
  );

  ebusDriverMux driverMux (
    .clk(clk),
    .aprDriving(aprDriving), .aprData(aprData),
    .piDriving(piDriving), .piData(piData),
    .mtrDriving(mtrDriving), .mtrData(mtrData),
    .ebusData(ebusData)
  );

endmodule

// File: ebusTb.sv
module ebusTb
  import ebusPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int txCount = 400;
  localparam int timeoutCycles = txCount * 6 + 100;

  logic                    clk;
  logic                    reset;
  logic                    cyc;
  logic                    stb;
  logic                    we;
  logic [wbAdrWidth-1:0]   adr;
  ebusWordT                datIn;
  ebusWordT                datOut;
  logic                    ack;
  logic [aprFlagCount-1:0] errorEvents;
  logic [piLevelCount-1:0] piReqIn;
  piLevelT                 piLevel;
  logic                    piRequest;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rngState = 32'h98ec;

  // reference state of the three devices
  logic [aprFlagCount-1:0] flagsM = '0;
  logic [aprFlagCount-1:0] enM = '0;
  piLevelT                 aprLvlM = '0;
  ebusWordT                breakM = '0;
  logic [piLevelCount-1:0] piOnM = '0;
  logic                    sysOnM = 1'b0;
  ebusWordT                mtrBase = '0;
  logic                    mtrEnM = 1'b0;
  int                      mtrLast = 0;

  ebusTop i_dut (
    .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datIn(datIn), .datOut(datOut), .ack(ack), .errorEvents(errorEvents),
    .piReqIn(piReqIn), .piLevel(piLevel), .piRequest(piRequest)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("timeout: run passed %0d cycles with %0d errors", timeoutCycles, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic checkWord(input string name, input ebusWordT got, input ebusWordT exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkLevel(input string name, input piLevelT got, input piLevelT exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h expected %h", name, got, exp);
    end
  endtask

  // the APR request shows up at its assigned level, never at level 0
  function automatic logic [piLevelCount-1:0] aprMaskModel();
    logic [piLevelCount-1:0] mask;
    for (int i = 0; i < piLevelCount; i++) begin
      mask[i] = (|(flagsM & enM)) && (aprLvlM == piLevelT'(i + 1));
    end
    return mask;
  endfunction

  function automatic piLevelT lowestOf(input logic [piLevelCount-1:0] bits);
    piLevelT lvl;
    lvl = '0;
    for (int i = 0; i < piLevelCount; i++) begin
      if (bits[i] && (lvl == '0)) begin
        lvl = piLevelT'(i + 1);
      end
    end
    return lvl;
  endfunction

  // value on the bus at edge edgeNum, taken from the state before that edge
  function automatic ebusWordT predictRead(input logic [2:0] dev, input ebusFuncT func,
                                           input int edgeNum);
    ebusWordT w;
    w = '0;
    if ((func == funcConi) || (func == funcDatai)) begin
      if (dev == devApr) begin
        if (func == funcConi) begin
          w[7:0]   = flagsM;
          w[15:8]  = enM;
          w[18:16] = aprLvlM;
        end else begin
          w = breakM;
        end
      end else if ((dev == devPi) && (func == funcConi)) begin
        w[6:0]  = piOnM;
        w[7]    = sysOnM;
        w[14:8] = piReqIn | aprMaskModel();
      end else if (dev == devMtr) begin
        if (func == funcConi) begin
          w[0] = mtrEnM;
        end else begin
          w = mtrBase + (mtrEnM ? ebusWordT'(edgeNum - 1 - mtrLast) : '0);
        end
      end
    end
    return w;
  endfunction

  task automatic applyWrite(input logic [2:0] dev, input ebusFuncT func, input ebusWordT data,
                            input logic [aprFlagCount-1:0] ev, input int edgeNum);
    if ((dev == devApr) && (func == funcCono)) begin
      flagsM  = (flagsM & ~data[15:8]) | data[7:0];
      enM     = data[23:16];
      aprLvlM = data[26:24];
    end
    if ((dev == devApr) && (func == funcDatao)) begin
      breakM = data;
    end
    if ((dev == devPi) && (func == funcCono)) begin
      if (data[16]) begin
        piOnM  = '0;
        sysOnM = 1'b0;
      end
      piOnM = (piOnM & ~data[13:7]) | data[6:0];
      if (data[15]) sysOnM = 1'b0;
      if (data[14]) sysOnM = 1'b1;
    end
    if ((dev == devMtr) && (func == funcCono)) begin
      mtrBase = data[1] ? '0 : mtrBase + (mtrEnM ? ebusWordT'(edgeNum - mtrLast) : '0);
      mtrEnM  = data[0];
      mtrLast = edgeNum;
    end
    flagsM = flagsM | ev;
  endtask

  // one Wishbone cycle; ev is sampled on the same edge as a CONO write
  task automatic runTransaction(input logic [2:0] dev, input ebusFuncT func,
                                input ebusWordT data, input logic [aprFlagCount-1:0] ev);
    int                      waited;
    int                      reqEdge;
    ebusWordT                expRead;
    logic [piLevelCount-1:0] active;
    reqEdge = cycles + 2;
    expRead = predictRead(dev, func, reqEdge);
    applyWrite(dev, func, data, ev, reqEdge);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = func[1];
    adr   = {dev, func};
    datIn = data;
    waited = 0;
    while (!ack && (waited < 8)) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited == 1) errorEvents = ev;
      if (waited == 2) errorEvents = '0;
    end
    if (!ack) begin
      errors++;
      $display("no ack within 8 cycles for device %0d function %0d", dev, func);
    end else if (waited != 3) begin
      errors++;
      $display("ack came %0d cycles after stb instead of 3", waited);
    end
    checkWord("datOut", datOut, expRead);
    @(posedge clk);
    #1;
    if (ack) begin
      errors++;
      $display("ack stayed high for more than one cycle");
    end
    cyc = 1'b0;
    stb = 1'b0;
    errorEvents = '0;
    active = (piReqIn | aprMaskModel()) & piOnM & {piLevelCount{sysOnM}};
    checkLevel("piLevel", piLevel, lowestOf(active));
    checkBit("piRequest", piRequest, |active);
  endtask

  initial begin
    logic [31:0]             r;
    logic [31:0]             r2;
    logic [2:0]              dev;
    ebusFuncT                func;
    ebusWordT                data;
    logic [aprFlagCount-1:0] ev;
    reset       = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    datIn       = '0;
    errorEvents = '0;
    piReqIn     = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    checkBit("ack", ack, 1'b0);
    checkBit("piRequest", piRequest, 1'b0);
    checkLevel("piLevel", piLevel, '0);
    for (int n = 0; n < txCount; n++) begin
      r    = nextRand();
      r2   = nextRand();
      dev  = {1'b0, r[1:0]};
      func = ebusFuncT'(r[3:2]);
      data = {r[15:12], r2};
      ev   = '0;
      // a rare single-bit error event
      if (r[18:16] == 3'd0) begin
        ev[r[21:19]] = 1'b1;
      end
      if (r[23:22] == 2'd0) begin
        piReqIn = r[30:24];
      end
      // now and then the master leaves the bus idle for a cycle
      if (r[31]) begin
        @(posedge clk);
        #1;
      end
      runTransaction(dev, func, data, ev);
    end
    $display("run finished: %0d transactions, %0d errors", txCount, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
ebusPkg.sv
ebusHostBridge.sv
aprRegs.sv
piCtrl.sv
mtrTimeBase.sv
ebusDriverMux.sv
ebusTop.sv
ebusTb.sv

// File: run.sh
#!/bin/sh
# build and run the EBUS testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f compile.f --top-module ebusTb -o ebusSim
./obj_dir/ebusSim > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
